// File: design/vec_mul_settings.svh
`ifndef VEC_MUL_SETTINGS_SVH
`define VEC_MUL_SETTINGS_SVH

// Datapath word width in bits
`define VM_ELEN 64

// Width of an element count
`define VM_VLEN_W 8

// Instruction ids and how many of them can be in flight
`define VM_ID_W 2
`define VM_NR_VINSN 4

// Queue depths
`define VM_VINSN_DEPTH 4
`define VM_RESULT_DEPTH 2

// Pipeline registers in the SIMD multiplier
`define VM_MUL_STAGES 2

// Register-file word address width
`define VM_ADDR_W 8

`endif

// File: design/vec_mul_pkg.sv
`include "vec_mul_settings.svh"

package vec_mul_pkg;

  typedef logic [`VM_ELEN-1:0]   elen_t;
  typedef logic [`VM_ELEN/8-1:0] strb_t;
  typedef logic [`VM_VLEN_W-1:0] vlen_t;
  typedef logic [`VM_ID_W-1:0]   vid_t;
  typedef logic [`VM_ADDR_W-1:0] vaddr_t;
  typedef logic [4:0]            vreg_t;

  // Element width, log2 of the byte count
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  typedef enum logic [1:0] {
    VMUL   = 2'd0,
    VMACC  = 2'd1,
    VMERGE = 2'd2
  } vop_e;

  typedef struct packed {
    vid_t  id;
    vop_e  op;
    vew_e  vew;
    vlen_t vl;
    vreg_t vd;
    // Set for an unmasked instruction
    logic  vm;
    logic  use_scalar;
    elen_t scalar;
  } vinsn_t;

  typedef struct packed {
    elen_t vs1;
    elen_t vs2;
    elen_t vd;
  } operands_t;

  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } vrf_wr_t;

  typedef struct packed {
    vop_e  op;
    vew_e  vew;
    elen_t a;
    elen_t b;
    elen_t c;
    strb_t mask;
  } mul_req_t;

  // Elements held by one datapath word
  function automatic logic [3:0] word_elems(vew_e vew);
    return 4'd8 >> vew;
  endfunction

endpackage

// File: design/vinsn_queue.sv
`timescale 1ns/10ps
`include "vec_mul_settings.svh"

module vinsn_queue (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  vec_mul_pkg::vinsn_t     vinsn_i,
  input  logic                    vinsn_valid_i,
  output logic                    vinsn_ready_o,
  input  logic                    issue_fire_i,
  input  logic                    proc_fire_i,
  input  logic                    commit_fire_i,
  output vec_mul_pkg::vinsn_t     issue_vinsn_o,
  output logic                    issue_valid_o,
  output vec_mul_pkg::vlen_t      issue_cnt_o,
  output vec_mul_pkg::vinsn_t     proc_vinsn_o,
  output logic                    proc_valid_o,
  output vec_mul_pkg::vlen_t      proc_cnt_o,
  output vec_mul_pkg::vinsn_t     commit_vinsn_o,
  output logic                    commit_valid_o,
  output logic [`VM_NR_VINSN-1:0] vinsn_done_o
);

  localparam int unsigned DEPTH = `VM_VINSN_DEPTH;
  localparam int unsigned PNT_W = $clog2(DEPTH);
  // Phases in order: issue, processing, commit
  localparam int unsigned NR_PHASES = 3;
  localparam int unsigned COMMIT = NR_PHASES - 1;

  typedef logic [PNT_W-1:0] pnt_t;
  typedef logic [PNT_W:0]   occ_t;

  vec_mul_pkg::vinsn_t mem_q [DEPTH];

  pnt_t                                accept_pnt_q;
  pnt_t               [NR_PHASES-1:0] pnt_d, pnt_q;
  // Instructions that have not yet left each phase
  occ_t               [NR_PHASES-1:0] occ_d, occ_q;
  // Remaining elements of the head instruction of each phase
  vec_mul_pkg::vlen_t [NR_PHASES-1:0] cnt_d, cnt_q;
  logic               [NR_PHASES-1:0] fire;
  logic                                accept;
  logic                                commit_last;

  function automatic pnt_t next_pnt(pnt_t pnt);
    return (pnt == pnt_t'(DEPTH - 1)) ? '0 : pnt + 1'b1;
  endfunction

  assign fire          = {commit_fire_i, proc_fire_i, issue_fire_i};
  // Commit is the last phase to let go of an entry
  assign vinsn_ready_o = (occ_q[COMMIT] != occ_t'(DEPTH));
  assign accept        = vinsn_valid_i & vinsn_ready_o;

  always_comb begin
    vec_mul_pkg::vinsn_t head;
    vec_mul_pkg::vlen_t  step;

    pnt_d       = pnt_q;
    occ_d       = occ_q;
    cnt_d       = cnt_q;
    commit_last = 1'b0;

    for (int p = 0; p < NR_PHASES; p++) begin
      head = mem_q[pnt_q[p]];
      step = vec_mul_pkg::vlen_t'(vec_mul_pkg::word_elems(head.vew));
      // The last word may be partly filled
      if (step > cnt_q[p]) begin
        step = cnt_q[p];
      end

      if (fire[p]) begin
        cnt_d[p] = cnt_q[p] - step;
        if (cnt_d[p] == '0) begin
          occ_d[p] = occ_q[p] - 1'b1;
          pnt_d[p] = next_pnt(pnt_q[p]);
          if (p == COMMIT) begin
            commit_last = 1'b1;
          end
          // Move on to the next queued instruction
          if (occ_d[p] != '0) begin
            cnt_d[p] = mem_q[pnt_d[p]].vl;
          end
        end
      end

      if (accept) begin
        // An empty phase starts on the new instruction right away
        if (occ_d[p] == '0) begin
          cnt_d[p] = vinsn_i.vl;
        end
        occ_d[p] = occ_d[p] + 1'b1;
      end
    end
  end

  always_comb begin
    vinsn_done_o = '0;
    if (commit_last) begin
      vinsn_done_o[commit_vinsn_o.id] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      pnt_q        <= '0;
      occ_q        <= '0;
      cnt_q        <= '0;
    end else begin
      pnt_q <= pnt_d;
      occ_q <= occ_d;
      cnt_q <= cnt_d;
      if (accept) begin
        accept_pnt_q <= next_pnt(accept_pnt_q);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      mem_q[accept_pnt_q] <= vinsn_i;
    end
  end

  assign issue_vinsn_o  = mem_q[pnt_q[0]];
  assign issue_valid_o  = (occ_q[0] != '0);
  assign issue_cnt_o    = cnt_q[0];
  assign proc_vinsn_o   = mem_q[pnt_q[1]];
  assign proc_valid_o   = (occ_q[1] != '0);
  assign proc_cnt_o     = cnt_q[1];
  assign commit_vinsn_o = mem_q[pnt_q[COMMIT]];
  assign commit_valid_o = (occ_q[COMMIT] != '0);

endmodule

// File: design/simd_multiplier.sv
`timescale 1ns/10ps
`include "vec_mul_settings.svh"

module simd_multiplier (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  vec_mul_pkg::mul_req_t req_i,
  input  logic                  valid_i,
  output logic                  ready_o,
  output vec_mul_pkg::elen_t    result_o,
  output vec_mul_pkg::strb_t    mask_o,
  output logic                  valid_o,
  input  logic                  ready_i
);

  localparam int unsigned STAGES = `VM_MUL_STAGES;

  vec_mul_pkg::elen_t product;
  vec_mul_pkg::elen_t addend;

  vec_mul_pkg::elen_t res_q  [STAGES];
  vec_mul_pkg::strb_t mask_q [STAGES];
  logic [STAGES-1:0]  vld_q;
  logic               advance;

  // Accumulate onto vd only for VMACC
  assign addend = (req_i.op == vec_mul_pkg::VMACC) ? req_i.c : '0;

  // Low half of each product, sized to the target slice
  always_comb begin
    product = '0;
    case (req_i.vew)
      vec_mul_pkg::EW8: begin
        for (int e = 0; e < 8; e++) begin
          product[8*e +: 8] = req_i.a[8*e +: 8] * req_i.b[8*e +: 8] + addend[8*e +: 8];
        end
      end
      vec_mul_pkg::EW16: begin
        for (int e = 0; e < 4; e++) begin
          product[16*e +: 16] = req_i.a[16*e +: 16] * req_i.b[16*e +: 16]
                                + addend[16*e +: 16];
        end
      end
      vec_mul_pkg::EW32: begin
        for (int e = 0; e < 2; e++) begin
          product[32*e +: 32] = req_i.a[32*e +: 32] * req_i.b[32*e +: 32]
                                + addend[32*e +: 32];
        end
      end
      vec_mul_pkg::EW64: begin
        product = req_i.a * req_i.b + addend;
      end
      default: begin
        product = '0;
      end
    endcase
  end

  // Whole pipeline holds while the last stage waits
  assign advance = ~vld_q[STAGES-1] | ready_i;
  assign ready_o = advance;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_q <= '0;
    end else if (advance) begin
      for (int s = STAGES - 1; s > 0; s--) begin
        vld_q[s] <= vld_q[s-1];
      end
      vld_q[0] <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance) begin
      for (int s = STAGES - 1; s > 0; s--) begin
        res_q[s]  <= res_q[s-1];
        mask_q[s] <= mask_q[s-1];
      end
      res_q[0]  <= product;
      mask_q[0] <= req_i.mask;
    end
  end

  assign result_o = res_q[STAGES-1];
  assign mask_o   = mask_q[STAGES-1];
  assign valid_o  = vld_q[STAGES-1];

endmodule

// File: design/result_queue.sv
`timescale 1ns/10ps
`include "vec_mul_settings.svh"

module result_queue (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  vec_mul_pkg::vrf_wr_t wr_i,
  input  logic                 wr_valid_i,
  output logic                 full_o,
  output logic                 vrf_req_o,
  output vec_mul_pkg::vrf_wr_t vrf_wr_o,
  input  logic                 vrf_gnt_i
);

  localparam int unsigned DEPTH = `VM_RESULT_DEPTH;
  localparam int unsigned PNT_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  typedef logic [PNT_W-1:0] pnt_t;

  vec_mul_pkg::vrf_wr_t mem_q [DEPTH];

  pnt_t           wr_pnt_q, rd_pnt_q;
  logic [PNT_W:0] cnt_q;
  logic           push, pop;

  function automatic pnt_t next_pnt(pnt_t pnt);
    return (pnt == pnt_t'(DEPTH - 1)) ? '0 : pnt + 1'b1;
  endfunction

  assign full_o    = (cnt_q == DEPTH);
  assign push      = wr_valid_i & ~full_o;
  // Head entry stays on the bus until granted
  assign vrf_req_o = (cnt_q != '0);
  assign vrf_wr_o  = mem_q[rd_pnt_q];
  assign pop       = vrf_req_o & vrf_gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_pnt_q <= next_pnt(wr_pnt_q);
      end
      if (pop) begin
        rd_pnt_q <= next_pnt(rd_pnt_q);
      end
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_pnt_q] <= wr_i;
    end
  end

endmodule

// File: design/vec_mul_unit.sv
`timescale 1ns/10ps
`include "vec_mul_settings.svh"

module vec_mul_unit (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  vec_mul_pkg::vinsn_t     vinsn_i,
  input  logic                    vinsn_valid_i,
  output logic                    vinsn_ready_o,
  input  vec_mul_pkg::operands_t  operands_i,
  input  logic                    operands_valid_i,
  output logic                    operands_ready_o,
  input  vec_mul_pkg::strb_t      mask_i,
  input  logic                    mask_valid_i,
  output logic                    mask_ready_o,
  output logic                    vrf_req_o,
  output vec_mul_pkg::vrf_wr_t    vrf_wr_o,
  input  logic                    vrf_gnt_i,
  output logic [`VM_NR_VINSN-1:0] vinsn_done_o
);

  localparam int unsigned STRB_W = `VM_ELEN / 8;

  vec_mul_pkg::vinsn_t   issue_vinsn, proc_vinsn, commit_vinsn;
  logic                  issue_valid, proc_valid, commit_valid;
  vec_mul_pkg::vlen_t    issue_cnt, proc_cnt;
  logic                  issue_fire, proc_fire, commit_fire;
  logic                  issue_ok, issue_is_merge, proc_is_merge;
  logic                  merge_ready, unit_ready;
  vec_mul_pkg::elen_t    scalar_rep, merge_word;
  vec_mul_pkg::strb_t    mask_bytes, issue_tail, issue_be;
  vec_mul_pkg::mul_req_t mul_req;
  logic                  mul_in_valid, mul_in_ready, mul_out_valid, mul_out_ready;
  vec_mul_pkg::elen_t    mul_result;
  vec_mul_pkg::strb_t    mul_be;
  logic                  unit_valid;
  vec_mul_pkg::elen_t    unit_result;
  vec_mul_pkg::strb_t    unit_be;
  vec_mul_pkg::vrf_wr_t  rq_wr;
  logic                  rq_full;
  vec_mul_pkg::vlen_t    word_idx;

  // Bytes of the valid elements in a word with cnt elements left
  function automatic vec_mul_pkg::strb_t tail_be(vec_mul_pkg::vlen_t cnt,
                                                 vec_mul_pkg::vew_e vew);
    vec_mul_pkg::vlen_t n;
    vec_mul_pkg::strb_t be;
    n = vec_mul_pkg::vlen_t'(vec_mul_pkg::word_elems(vew));
    if (cnt < n) begin
      n = cnt;
    end
    for (int b = 0; b < STRB_W; b++) begin
      be[b] = vec_mul_pkg::vlen_t'(b >> vew) < n;
    end
    return be;
  endfunction

  vinsn_queue i_vinsn_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .vinsn_i       (vinsn_i),
    .vinsn_valid_i (vinsn_valid_i),
    .vinsn_ready_o (vinsn_ready_o),
    .issue_fire_i  (issue_fire),
    .proc_fire_i   (proc_fire),
    .commit_fire_i (commit_fire),
    .issue_vinsn_o (issue_vinsn),
    .issue_valid_o (issue_valid),
    .issue_cnt_o   (issue_cnt),
    .proc_vinsn_o  (proc_vinsn),
    .proc_valid_o  (proc_valid),
    .proc_cnt_o    (proc_cnt),
    .commit_vinsn_o(commit_vinsn),
    .commit_valid_o(commit_valid),
    .vinsn_done_o  (vinsn_done_o)
  );

  always_comb begin
    scalar_rep = issue_vinsn.scalar;
    case (issue_vinsn.vew)
      vec_mul_pkg::EW8:  scalar_rep = {8{issue_vinsn.scalar[7:0]}};
      vec_mul_pkg::EW16: scalar_rep = {4{issue_vinsn.scalar[15:0]}};
      vec_mul_pkg::EW32: scalar_rep = {2{issue_vinsn.scalar[31:0]}};
      default:           scalar_rep = issue_vinsn.scalar;
    endcase
  end

  // Each byte follows the mask bit of the element's first byte
  always_comb begin
    for (int b = 0; b < STRB_W; b++) begin
      mask_bytes[b] = mask_i[(b >> issue_vinsn.vew) << issue_vinsn.vew];
      merge_word[8*b +: 8] = (issue_vinsn.vm || mask_bytes[b]) ? scalar_rep[8*b +: 8]
                                                                : operands_i.vs2[8*b +: 8];
    end
  end

  assign issue_tail = tail_be(issue_cnt, issue_vinsn.vew);
  assign issue_be   = issue_tail & (issue_vinsn.vm ? '1 : mask_bytes);

  assign issue_is_merge = (issue_vinsn.op == vec_mul_pkg::VMERGE);
  assign proc_is_merge  = (proc_vinsn.op == vec_mul_pkg::VMERGE);
  assign issue_ok       = issue_valid & operands_valid_i & (mask_valid_i | issue_vinsn.vm);

  // A merge word lands in the result queue in its issue cycle
  assign merge_ready = ~rq_full & proc_valid & proc_is_merge;
  assign unit_ready  = issue_is_merge ? merge_ready : mul_in_ready;
  assign issue_fire  = issue_ok & unit_ready;

  assign operands_ready_o = issue_fire;
  assign mask_ready_o     = issue_fire & ~issue_vinsn.vm;

  assign mul_req.op   = issue_vinsn.op;
  assign mul_req.vew  = issue_vinsn.vew;
  assign mul_req.a    = issue_vinsn.use_scalar ? scalar_rep : operands_i.vs1;
  assign mul_req.b    = operands_i.vs2;
  assign mul_req.c    = operands_i.vd;
  // The byte enable travels with the word as its mask tag
  assign mul_req.mask = issue_be;
  assign mul_in_valid = issue_ok & ~issue_is_merge;
  assign mul_out_ready = ~rq_full & ~proc_is_merge;

  simd_multiplier i_simd_multiplier (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (mul_req),
    .valid_i (mul_in_valid),
    .ready_o (mul_in_ready),
    .result_o(mul_result),
    .mask_o  (mul_be),
    .valid_o (mul_out_valid),
    .ready_i (mul_out_ready)
  );

  always_comb begin
    if (proc_is_merge) begin
      unit_valid  = issue_fire & issue_is_merge;
      unit_result = merge_word;
      unit_be     = issue_tail;
    end else begin
      unit_valid  = mul_out_valid;
      unit_result = mul_result;
      unit_be     = mul_be;
    end
  end

  assign proc_fire = unit_valid & proc_valid & ~rq_full;

  // Words already written, from the processed element count
  assign word_idx = (proc_vinsn.vl - proc_cnt) >> (2'd3 - 2'(proc_vinsn.vew));

  assign rq_wr.id    = proc_vinsn.id;
  assign rq_wr.addr  = vec_mul_pkg::vaddr_t'({proc_vinsn.vd, 3'b000}) + word_idx;
  assign rq_wr.wdata = unit_result;
  assign rq_wr.be    = unit_be;

  result_queue i_result_queue (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .wr_i      (rq_wr),
    .wr_valid_i(proc_fire),
    .full_o    (rq_full),
    .vrf_req_o (vrf_req_o),
    .vrf_wr_o  (vrf_wr_o),
    .vrf_gnt_i (vrf_gnt_i)
  );

  // Every granted word belongs to the commit instruction
  assign commit_fire = vrf_req_o & vrf_gnt_i & commit_valid & (vrf_wr_o.id == commit_vinsn.id);

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int unsigned PERIOD_NS    = 8,
  parameter int unsigned RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release away from the rising edge
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// File: testbench/vec_mul_unit_asserts.sv
`timescale 1ns/10ps
`include "vec_mul_settings.svh"

module vec_mul_unit_asserts (
  input logic                    clk_i,
  input logic                    rst_ni,
  input logic                    vrf_req_i,
  input vec_mul_pkg::vrf_wr_t    vrf_wr_i,
  input logic                    vrf_gnt_i,
  input logic [`VM_NR_VINSN-1:0] vinsn_done_i,
  input logic                    operands_valid_i,
  input logic                    operands_ready_i
);

  int assert_fails = 0;

  // A waiting request keeps its entry on the bus
  wr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      vrf_req_i && !vrf_gnt_i |=> vrf_req_i && $stable(vrf_wr_i))
    else begin
      $error("vrf_wr_o changed while a request waited for its grant");
      assert_fails++;
    end

  no_done_in_reset: assert property (@(posedge clk_i) !rst_ni |-> vinsn_done_i == '0)
    else begin
      $error("vinsn_done_o pulsed during reset");
      assert_fails++;
    end

  operands_handshake: assert property (@(posedge clk_i) disable iff (!rst_ni)
      operands_ready_i |-> operands_valid_i)
    else begin
      $error("operands_ready_o pulsed without operands_valid_i");
      assert_fails++;
    end

endmodule

bind vec_mul_unit vec_mul_unit_asserts i_asserts (
  .clk_i           (clk_i),
  .rst_ni          (rst_ni),
  .vrf_req_i       (vrf_req_o),
  .vrf_wr_i        (vrf_wr_o),
  .vrf_gnt_i       (vrf_gnt_i),
  .vinsn_done_i    (vinsn_done_o),
  .operands_valid_i(operands_valid_i),
  .operands_ready_i(operands_ready_o)
);

// File: testbench/tb_vec_mul_unit.sv
`timescale 1ns/10ps
`include "vec_mul_settings.svh"

module tb_vec_mul_unit;

  localparam int CLK_PERIOD = 8;
  // Expected length of each test in cycles
  localparam int T_RESET    = 10;
  localparam int T_VMUL     = 60;
  localparam int T_VMACC    = 20;
  localparam int T_VMERGE   = 30;
  localparam int T_MASKED   = 30;
  localparam int T_BACK     = 60;
  localparam int TOTAL_CYCLES = T_RESET + T_VMUL + T_VMACC + T_VMERGE + T_MASKED + T_BACK;

  typedef logic [`VM_NR_VINSN-1:0] done_t;

  logic                   clk, rst_n;
  vec_mul_pkg::vinsn_t    vinsn_i;
  logic                   vinsn_valid_i, vinsn_ready_o;
  vec_mul_pkg::operands_t operands_i;
  logic                   operands_valid_i, operands_ready_o;
  vec_mul_pkg::strb_t     mask_i;
  logic                   mask_valid_i, mask_ready_o;
  logic                   vrf_req_o, vrf_gnt_i;
  vec_mul_pkg::vrf_wr_t   vrf_wr_o;
  done_t                  vinsn_done_o;

  // Stimulus waiting to be taken by the DUT
  vec_mul_pkg::vinsn_t    ins_q[$];
  vec_mul_pkg::operands_t opd_q[$];
  vec_mul_pkg::strb_t     msk_q[$];
  logic                   vm_q[$];
  // Model output and observed register-file writes
  vec_mul_pkg::vrf_wr_t   exp_wr_q[$], got_wr_q[$];
  done_t                  exp_done_q[$], got_done_q[$];

  logic [63:0] rng_state = 64'd77804;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(5)) i_clock_gen (
    .clk_o (clk),
    .rst_no(rst_n)
  );

  vec_mul_unit UUT (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .vinsn_i         (vinsn_i),
    .vinsn_valid_i   (vinsn_valid_i),
    .vinsn_ready_o   (vinsn_ready_o),
    .operands_i      (operands_i),
    .operands_valid_i(operands_valid_i),
    .operands_ready_o(operands_ready_o),
    .mask_i          (mask_i),
    .mask_valid_i    (mask_valid_i),
    .mask_ready_o    (mask_ready_o),
    .vrf_req_o       (vrf_req_o),
    .vrf_wr_o        (vrf_wr_o),
    .vrf_gnt_i       (vrf_gnt_i),
    .vinsn_done_o    (vinsn_done_o)
  );

  function automatic logic [63:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 7);
    rng_state = rng_state ^ (rng_state << 17);
    return rng_state;
  endfunction

  task automatic compare(string name, logic [63:0] got, logic [63:0] exp);
    if (got !== exp) begin
      $display("error: %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  function automatic vec_mul_pkg::vinsn_t make_insn(vec_mul_pkg::vid_t id,
      vec_mul_pkg::vop_e op, vec_mul_pkg::vew_e vew, int vl, int vd, logic vm,
      logic use_scalar);
    vec_mul_pkg::vinsn_t ins;
    ins.id         = id;
    ins.op         = op;
    ins.vew        = vew;
    ins.vl         = vec_mul_pkg::vlen_t'(vl);
    ins.vd         = vec_mul_pkg::vreg_t'(vd);
    ins.vm         = vm;
    ins.use_scalar = use_scalar;
    ins.scalar     = next_rand();
    return ins;
  endfunction

  // Reference for word w of an instruction, from the element and address rules
  function automatic vec_mul_pkg::vrf_wr_t model_word(vec_mul_pkg::vinsn_t ins, int w,
      vec_mul_pkg::operands_t opd, vec_mul_pkg::strb_t mask);
    vec_mul_pkg::vrf_wr_t wr;
    int          esz, nel, nvalid;
    logic [63:0] emask, a, b, c, r;
    logic        mbit;
    esz    = 8 << ins.vew;
    nel    = 8 >> ins.vew;
    nvalid = int'(ins.vl) - w * nel;
    if (nvalid > nel) begin
      nvalid = nel;
    end
    emask    = (esz == 64) ? '1 : (64'd1 << esz) - 64'd1;
    wr.id    = ins.id;
    wr.addr  = vec_mul_pkg::vaddr_t'(int'(ins.vd) * 8 + w);
    wr.wdata = '0;
    wr.be    = '0;
    for (int e = 0; e < nel; e++) begin
      a    = (ins.use_scalar ? ins.scalar : (opd.vs1 >> (e * esz))) & emask;
      b    = (opd.vs2 >> (e * esz)) & emask;
      c    = (opd.vd >> (e * esz)) & emask;
      mbit = mask[e * (esz / 8)];
      case (ins.op)
        vec_mul_pkg::VMUL:  r = a * b;
        vec_mul_pkg::VMACC: r = a * b + c;
        default:            r = (ins.vm || mbit) ? ins.scalar : b;
      endcase
      wr.wdata = wr.wdata | ((r & emask) << (e * esz));
      if (e < nvalid && (ins.op == vec_mul_pkg::VMERGE || ins.vm || mbit)) begin
        for (int k = 0; k < esz / 8; k++) begin
          wr.be[e * (esz / 8) + k] = 1'b1;
        end
      end
    end
    return wr;
  endfunction

  task automatic queue_insn(vec_mul_pkg::vinsn_t ins);
    vec_mul_pkg::operands_t opd;
    vec_mul_pkg::strb_t     mask;
    int                     nel, nwords;
    nel    = 8 >> ins.vew;
    nwords = (int'(ins.vl) + nel - 1) / nel;
    ins_q.push_back(ins);
    for (int w = 0; w < nwords; w++) begin
      opd.vs1 = next_rand();
      opd.vs2 = next_rand();
      opd.vd  = next_rand();
      mask    = vec_mul_pkg::strb_t'(next_rand());
      opd_q.push_back(opd);
      msk_q.push_back(mask);
      vm_q.push_back(ins.vm);
      exp_wr_q.push_back(model_word(ins, w, opd, mask));
      exp_done_q.push_back((w == nwords - 1) ? done_t'(1) << ins.id : done_t'(0));
    end
  endtask

  task automatic compare_writes();
    vec_mul_pkg::vrf_wr_t got, exp;
    done_t                got_done, exp_done;
    logic [63:0]          bmask;
    while (exp_wr_q.size() > 0 && got_wr_q.size() > 0) begin
      got      = got_wr_q.pop_front();
      exp      = exp_wr_q.pop_front();
      got_done = got_done_q.pop_front();
      exp_done = exp_done_q.pop_front();
      for (int b = 0; b < 8; b++) begin
        bmask[8*b +: 8] = {8{exp.be[b]}};
      end
      compare("vrf_wr_o.id", got.id, exp.id);
      compare("vrf_wr_o.addr", got.addr, exp.addr);
      compare("vrf_wr_o.be", got.be, exp.be);
      // Disabled bytes carry no defined data
      compare("vrf_wr_o.wdata", got.wdata & bmask, exp.wdata & bmask);
      compare("vinsn_done_o", got_done, exp_done);
    end
    if (got_wr_q.size() != 0) begin
      $display("%0d register-file writes arrived that no instruction asked for",
               got_wr_q.size());
      errors++;
    end
    got_wr_q.delete();
    got_done_q.delete();
    exp_wr_q.delete();
    exp_done_q.delete();
  endtask

  // Wait for every expected write, then a few more cycles for strays
  task automatic drain(int limit);
    int n;
    n = 0;
    while (got_wr_q.size() < exp_wr_q.size() && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (got_wr_q.size() < exp_wr_q.size()) begin
      $display("timeout: only %0d of %0d register-file writes arrived",
               got_wr_q.size(), exp_wr_q.size());
      errors++;
    end
    repeat (3) @(negedge clk);
    compare_writes();
  endtask

  task automatic end_test(string name, int err0);
    tests_run++;
    if (errors != err0) begin
      tests_failed++;
    end
    $display("test %-14s %s, %0d errors", name, (errors == err0) ? "ok" : "failed",
             errors - err0);
  endtask

  task automatic test_reset_state();
    int err0;
    err0 = errors;
    @(negedge clk);
    compare("vinsn_done_o", vinsn_done_o, 0);
    wait (rst_n === 1'b1);
    @(negedge clk);
    compare("vrf_req_o", vrf_req_o, 0);
    compare("operands_ready_o", operands_ready_o, 0);
    compare("mask_ready_o", mask_ready_o, 0);
    compare("vinsn_done_o", vinsn_done_o, 0);
    compare("vinsn_ready_o", vinsn_ready_o, 1);
    end_test("reset_state", err0);
  endtask

  task automatic test_vmul_widths();
    int err0;
    err0 = errors;
    vrf_gnt_i = 1'b1;
    queue_insn(make_insn(0, vec_mul_pkg::VMUL, vec_mul_pkg::EW8, 8, 1, 1'b1, 1'b0));
    queue_insn(make_insn(1, vec_mul_pkg::VMUL, vec_mul_pkg::EW16, 8, 2, 1'b1, 1'b0));
    queue_insn(make_insn(2, vec_mul_pkg::VMUL, vec_mul_pkg::EW32, 8, 3, 1'b1, 1'b0));
    queue_insn(make_insn(3, vec_mul_pkg::VMUL, vec_mul_pkg::EW64, 8, 4, 1'b1, 1'b0));
    drain(T_VMUL);
    // Last word holds a single element
    queue_insn(make_insn(1, vec_mul_pkg::VMUL, vec_mul_pkg::EW16, 5, 6, 1'b1, 1'b0));
    drain(T_VMUL);
    end_test("vmul_widths", err0);
  endtask

  task automatic test_vmacc_scalar();
    int err0;
    err0 = errors;
    queue_insn(make_insn(2, vec_mul_pkg::VMACC, vec_mul_pkg::EW16, 8, 7, 1'b1, 1'b1));
    drain(T_VMACC);
    end_test("vmacc_scalar", err0);
  endtask

  task automatic test_vmerge_masked();
    int err0;
    err0 = errors;
    queue_insn(make_insn(3, vec_mul_pkg::VMERGE, vec_mul_pkg::EW32, 8, 9, 1'b0, 1'b1));
    queue_insn(make_insn(0, vec_mul_pkg::VMERGE, vec_mul_pkg::EW8, 6, 12, 1'b0, 1'b1));
    drain(T_VMERGE);
    end_test("vmerge_masked", err0);
  endtask

  task automatic test_masked_vmul();
    int err0;
    err0 = errors;
    queue_insn(make_insn(0, vec_mul_pkg::VMUL, vec_mul_pkg::EW8, 8, 10, 1'b0, 1'b0));
    queue_insn(make_insn(1, vec_mul_pkg::VMUL, vec_mul_pkg::EW32, 3, 11, 1'b0, 1'b0));
    drain(T_MASKED);
    end_test("masked_vmul", err0);
  endtask

  task automatic test_backpressure();
    int err0, n;
    err0 = errors;
    n = 0;
    vrf_gnt_i = 1'b0;
    queue_insn(make_insn(0, vec_mul_pkg::VMUL, vec_mul_pkg::EW64, 2, 13, 1'b1, 1'b0));
    queue_insn(make_insn(1, vec_mul_pkg::VMACC, vec_mul_pkg::EW32, 4, 14, 1'b1, 1'b0));
    queue_insn(make_insn(2, vec_mul_pkg::VMERGE, vec_mul_pkg::EW16, 8, 15, 1'b0, 1'b1));
    queue_insn(make_insn(3, vec_mul_pkg::VMUL, vec_mul_pkg::EW8, 8, 16, 1'b1, 1'b0));
    while (ins_q.size() != 0 && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (ins_q.size() != 0) begin
      $display("the DUT took fewer than four instructions while grants were held");
      errors++;
    end
    compare("vinsn_ready_o", vinsn_ready_o, 0);
    while (n < 20) begin
      @(negedge clk);
      n++;
    end
    compare("vrf_req_o", vrf_req_o, 1);
    // Of the seven words, the result queue and the multiplier stages hold the first ones
    compare("operand words waiting", opd_q.size(), 7 - `VM_RESULT_DEPTH - `VM_MUL_STAGES);
    vrf_gnt_i = 1'b1;
    drain(T_BACK);
    end_test("backpressure", err0);
  endtask

  // Instruction and operand streams, driven on the falling edge
  initial begin
    forever begin
      @(negedge clk);
      vinsn_valid_i = (ins_q.size() > 0);
      if (ins_q.size() > 0) begin
        vinsn_i = ins_q[0];
      end
      operands_valid_i = (opd_q.size() > 0);
      mask_valid_i     = (opd_q.size() > 0);
      if (opd_q.size() > 0) begin
        operands_i = opd_q[0];
        mask_i     = msk_q[0];
      end
    end
  end

  always @(posedge clk) begin
    if (vinsn_valid_i && vinsn_ready_o) begin
      void'(ins_q.pop_front());
    end
    if (operands_valid_i && operands_ready_o) begin
      compare("mask_ready_o", mask_ready_o, !vm_q[0]);
      void'(opd_q.pop_front());
      void'(msk_q.pop_front());
      void'(vm_q.pop_front());
    end
  end

  // Register-file monitor
  always @(posedge clk) begin
    if (rst_n && vrf_req_o && vrf_gnt_i) begin
      got_wr_q.push_back(vrf_wr_o);
      got_done_q.push_back(vinsn_done_o);
    end else if (rst_n && vinsn_done_o != '0) begin
      $display("vinsn_done_o pulsed in a cycle without a register-file grant");
      errors++;
    end
  end

  initial begin
    #(TOTAL_CYCLES * 4 * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", TOTAL_CYCLES * 4);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    vinsn_i          = '0;
    vinsn_valid_i    = 1'b0;
    operands_i       = '0;
    operands_valid_i = 1'b0;
    mask_i           = '0;
    mask_valid_i     = 1'b0;
    vrf_gnt_i        = 1'b0;
    test_reset_state();
    test_vmul_widths();
    test_vmacc_scalar();
    test_vmerge_masked();
    test_masked_vmul();
    test_backpressure();
    errors += UUT.i_asserts.assert_fails;
    $display("tests run %0d, tests failed %0d, errors %0d, assertion failures %0d",
             tests_run, tests_failed, errors, UUT.i_asserts.assert_fails);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: vec_mul_unit.f
+incdir+design
design/vec_mul_pkg.sv
design/vinsn_queue.sv
design/simd_multiplier.sv
design/result_queue.sv
design/vec_mul_unit.sv
testbench/tb_clock_gen.sv
testbench/vec_mul_unit_asserts.sv
testbench/tb_vec_mul_unit.sv

// File: Bender.yml
package:
  name: vec_mul_unit

sources:
  - include_dirs:
      - design
    files:
      - design/vec_mul_pkg.sv
      - design/vinsn_queue.sv
      - design/simd_multiplier.sv
      - design/result_queue.sv
      - design/vec_mul_unit.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/tb_clock_gen.sv
      - testbench/vec_mul_unit_asserts.sv
      - testbench/tb_vec_mul_unit.sv
